// File: all.f
+incdir+include
+incdir+sim
src/bubl_pkg.sv
src/bubl_addr_decode.sv
src/bubl_cab_inputs.sv
src/bubl_ctrl_regs.sv
src/bubl_sound_link.sv
src/bubl_read_mux.sv
src/bubl_main_bus.sv
sim/bubl_main_tb.sv

// File: include/bubl_defines.svh
`ifndef BUBL_DEFINES_SVH
`define BUBL_DEFINES_SVH

////////////////////
// Bus widths

`define BUBL_ADDR_W        16   // Main CPU address
`define BUBL_DATA_W        8
`define BUBL_ROM_ADDR_W    18   // Byte address into the main ROM region

////////////////////
// ROM banking

`define BUBL_BANK_W        3
// Banked window starts two 16kB pages above the fixed area
`define BUBL_BANK_BASE     2
`define BUBL_BUBL_BANK_XOR 4    // Bubble Bobble inverts the top bank bit

////////////////////
// Fixed read values

// Nothing mapped at the address
`define BUBL_FILL          8'hFF
`define BUBL_TOKIO_COMM    8'hBF  // Tokio shared RAM is not fitted
// Default vector, the MCU never rewrites it here
`define BUBL_INT_VECTOR    8'h2E

`endif

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module bubl_main_tb -f all.f -o bubl_sim &&
./obj_dir/bubl_sim | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null ||
{ echo "simulation did not pass"; exit 1; }

// File: sim/bubl_tests.svh
// Game dependent window bases
function automatic logic [`BUBL_ADDR_W-1:0] misc_addr(input bubl_pkg::game_t g);
    return g == bubl_pkg::GAME_TOKIO ? 16'hFA80 : 16'hFB40;
endfunction

function automatic logic [`BUBL_ADDR_W-1:0] sound_addr(input bubl_pkg::game_t g);
    return g == bubl_pkg::GAME_TOKIO ? 16'hFC00 : 16'hFA00;
endfunction

// Runs in the last reset cycle and returns on its falling edge
task automatic test_reset_values();
    @(negedge clk24);
    bus.addr = 16'h8000;   // Bank 0 plus the base
    @(negedge clk24);
    check_byte("reset rd_data", `BUBL_FILL, rd_data);
    check_rom_addr("reset rom_addr", {4'd2, 14'd0}, rom_addr);
    check_bit("reset snd_stb", 1'b0, snd_stb);
    check_bit("reset black_n", 1'b0, black_n);
    check_bit("reset flip", 1'b0, flip);
    check_bit("reset sub_rst_n", 1'b0, sub_rst_n);
    check_bit("reset main_flag", 1'b0, main_flag);
    check_bit("reset mcu_rst", 1'b1, mcu_rst);
    check_bit("reset snd_rstn", 1'b1, snd_rstn);
endtask

task automatic test_rom_banking();
    logic [31:0] r;
    logic [2:0]  bank;
    int          gi;
    for (gi = 0; gi < 2; gi++) begin
        game = gi == 0 ? bubl_pkg::GAME_BUBL : bubl_pkg::GAME_TOKIO;
        repeat (4) begin
            take_bits(8, r);
            mem_write(misc_addr(game), r[7:0]);
            bank = game == bubl_pkg::GAME_TOKIO ? r[2:0] : r[2:0] ^ 3'b100;
            take_bits(15, r);
            bus.addr = {1'b1, r[14:0]};
            @(negedge clk24);
            check_rom_addr("rom banked", {{1'b0, bank} + 4'd2, r[13:0]}, rom_addr);
            bus.addr = {1'b0, r[14:0]};
            @(negedge clk24);
            check_rom_addr("rom fixed", {3'b000, r[14:0]}, rom_addr);
        end
    end
endtask

task automatic test_read_mux();
    logic [31:0]             r;
    logic [`BUBL_DATA_W-1:0] d;
    int                      gi;
    for (gi = 0; gi < 2; gi++) begin
        game = gi == 0 ? bubl_pkg::GAME_BUBL : bubl_pkg::GAME_TOKIO;
        take_bits(32, r);
        {rom_data, vram_dout, pal_dout, work_dout} = r;
        take_bits(8, r);
        comm_dout = r[7:0];
        take_bits(13, r);
        mem_read({3'b000, r[12:0]}, 1, d);
        check_byte("read rom", rom_data, d);
        mem_read({3'b110, r[12:0]}, 1, d);
        check_byte("read vram", vram_dout, d);
        mem_read({7'b1111_100, r[8:0]}, 1, d);
        check_byte("read palette", pal_dout, d);
        mem_read({5'b11100, r[10:0]}, 1, d);
        check_byte("read work ram", work_dout, d);
        if (game == bubl_pkg::GAME_TOKIO) begin
            mem_read({7'b1111_111, r[8:0]}, 1, d);
            check_byte("read comm tokio", `BUBL_TOKIO_COMM, d);
            mem_read(16'hFB10, 1, d);   // Write only window
        end else begin
            mem_read({6'b1111_11, r[9:0]}, 1, d);
            check_byte("read comm bubl", comm_dout, d);
            mem_read(16'hFA90, 1, d);   // Hole in the map
        end
        check_byte("read unmapped", `BUBL_FILL, d);

        // Interrupt acknowledge without a memory request
        @(negedge clk24);
        bus.iorq_n = 1'b0;
        @(negedge clk24);
        check_byte("read vector", `BUBL_INT_VECTOR, rd_data);
        bus_idle();
    end
endtask

// Holds one bus cycle and compares the outward selects before releasing it
task automatic select_cycle(input string name, input logic [`BUBL_ADDR_W-1:0] addr,
                            input logic write, input logic [4:0] expected);
    @(negedge clk24);
    bus.addr   = addr;
    bus.mreq_n = 1'b0;
    bus.rd_n   = write;
    bus.wr_n   = ~write;
    @(negedge clk24);
    check_bit({name, " rom_cs"}, expected[4], rom_cs);
    check_bit({name, " vram_cs"}, expected[3], vram_cs);
    check_bit({name, " pal_cs"}, expected[2], pal_cs);
    check_bit({name, " work_cs"}, expected[1], work_cs);
    check_bit({name, " sub_nmi"}, expected[0], sub_nmi);
    bus_idle();
endtask

// Expected order is rom, vram, palette, work RAM, sub NMI
task automatic test_chip_selects();
    logic [31:0] r;
    int          gi;
    for (gi = 0; gi < 2; gi++) begin
        game = gi == 0 ? bubl_pkg::GAME_BUBL : bubl_pkg::GAME_TOKIO;
        take_bits(14, r);
        select_cycle("cs rom", {2'b10, r[13:0]}, 1'b0, 5'b10000);
        select_cycle("cs vram", {3'b110, r[12:0]}, 1'b0, 5'b01000);
        select_cycle("cs palette", {7'b1111_100, r[8:0]}, 1'b1, 5'b00100);
        select_cycle("cs work ram", {5'b11101, r[10:0]}, 1'b0, 5'b00010);
        if (game == bubl_pkg::GAME_TOKIO) begin
            select_cycle("cs sub_nmi tokio", {9'b1111_1011_1, r[6:0]}, 1'b1, 5'b00001);
            select_cycle("cs sub_nmi read", {9'b1111_1011_1, r[6:0]}, 1'b0, 5'b00000);
        end else begin
            select_cycle("cs sub_nmi bubl", {10'b1111_1011_00, r[5:0]}, 1'b1, 5'b00001);
            select_cycle("cs sub_nmi read", {10'b1111_1011_00, r[5:0]}, 1'b0, 5'b00000);
        end
    end
endtask

task automatic test_ctrl_regs();
    logic [31:0] r;
    logic [31:0] f;
    int          gi;
    for (gi = 0; gi < 2; gi++) begin
        game = gi == 0 ? bubl_pkg::GAME_BUBL : bubl_pkg::GAME_TOKIO;
        repeat (3) begin
            take_bits(8, r);
            mem_write(misc_addr(game), r[7:0]);
            check_bit("ctrl black_n", r[6], black_n);
            if (game == bubl_pkg::GAME_TOKIO) begin
                check_bit("ctrl sub_rst_n tokio", 1'b1, sub_rst_n);
                check_bit("ctrl mcu_rst tokio", 1'b1, mcu_rst);
                take_bits(1, f);
                mem_write(16'hFB00, {f[0], 7'h00});
                check_bit("ctrl flip tokio", f[0], flip);
                mem_write(16'hFA80, {~f[0], 7'h00});   // Misc must leave flip alone
                check_bit("ctrl flip kept", f[0], flip);
            end else begin
                check_bit("ctrl sub_rst_n bubl", r[4], sub_rst_n);
                check_bit("ctrl mcu_rst bubl", ~r[5], mcu_rst);
                check_bit("ctrl flip bubl", r[7], flip);
            end
        end
    end
endtask

task automatic test_sound_link();
    logic [31:0]             r;
    logic [`BUBL_DATA_W-1:0] d;
    int                      gi;
    for (gi = 0; gi < 2; gi++) begin
        game = gi == 0 ? bubl_pkg::GAME_BUBL : bubl_pkg::GAME_TOKIO;
        take_bits(8, r);
        mem_write(sound_addr(game), r[7:0]);
        check_byte("sound latch", r[7:0], snd_latch);
        check_bit("sound strobe high", 1'b1, snd_stb);
        @(negedge clk24);
        check_bit("sound strobe low", 1'b0, snd_stb);
        mem_write(sound_addr(game) + 16'd3, 8'h01);
        check_bit("sound reset on", 1'b0, snd_rstn);
        mem_write(sound_addr(game) + 16'd3, 8'h00);
        check_bit("sound reset off", 1'b1, snd_rstn);
        take_bits(8, r);
        main_latch = r[7:0];
        mem_read(sound_addr(game), 1, d);
        check_byte("sound read latch", main_latch, d);
    end
endtask

task automatic test_handshake();
    logic [31:0]             r;
    logic [`BUBL_DATA_W-1:0] d;
    int                      gi;
    int                      cycles;
    for (gi = 0; gi < 2; gi++) begin
        game = gi == 0 ? bubl_pkg::GAME_BUBL : bubl_pkg::GAME_TOKIO;
        take_bits(1, r);
        snd_flag = r[0];
        check_bit("flag idle", 1'b0, main_flag);
        main_stb = 1'b1;
        cycles   = 0;
        while (main_flag !== 1'b1 && cycles < 16) begin
            @(negedge clk24);
            cycles++;
        end
        if (main_flag !== 1'b1) begin
            $display("timeout: main_flag did not rise after a main_stb edge");
            timeouts++;
        end
        main_stb = 1'b0;
        mem_read(sound_addr(game) + 16'd1, 1, d);
        check_byte("handshake status", {6'h3F, 1'b1, snd_flag}, d);
        check_bit("flag cleared", 1'b0, main_flag);
    end
endtask

// Cabinet byte passes two registers on its way to rd_data
task automatic test_cabinet();
    logic [31:0]             r;
    logic [`BUBL_DATA_W-1:0] d;
    game = bubl_pkg::GAME_TOKIO;
    repeat (3) begin
        take_bits(32, r);
        cab = r;
        mem_read(16'hFA03, 2, d);
        check_byte("cabinet dipsw_a", cab.dipsw_a, d);
        mem_read(16'hFA04, 2, d);
        check_byte("cabinet dipsw_b", cab.dipsw_b, d);
        mem_read(16'hFA05, 2, d);
        check_byte("cabinet coin", {4'hF, ~cab.coin, 2'b11}, d);
        mem_read(16'hFA06, 2, d);
        check_byte("cabinet player 1", {1'b1, cab.start_button[0], cab.joy1[4], cab.joy1[5],
                                        cab.joy1[3:2], cab.joy1[0], cab.joy1[1]}, d);
        mem_read(16'hFA07, 2, d);
        check_byte("cabinet player 2", {1'b1, cab.start_button[1], cab.joy2[4], cab.joy2[5],
                                        cab.joy2[3:2], cab.joy2[0], cab.joy2[1]}, d);
        mem_read(16'hFA00, 2, d);
        check_byte("cabinet unused", `BUBL_FILL, d);
    end
endtask

// File: sim/bubl_main_tb.sv
`timescale 1ns/1ns
`include "bubl_defines.svh"

module bubl_main_tb;

logic                          clk24;
logic                          rst;
bubl_pkg::game_t               game;
bubl_pkg::cpu_bus_t            bus;
bubl_pkg::cab_in_t             cab;
logic [`BUBL_DATA_W-1:0]       rom_data, vram_dout, pal_dout, work_dout, comm_dout;
logic [`BUBL_DATA_W-1:0]       main_latch;
logic                          snd_flag;
logic                          main_stb;
logic [`BUBL_DATA_W-1:0]       rd_data;
logic [`BUBL_ROM_ADDR_W-1:0]   rom_addr;
logic                          rom_cs, vram_cs, pal_cs, work_cs, sub_nmi;
logic                          black_n, flip, sub_rst_n, mcu_rst;
logic [`BUBL_DATA_W-1:0]       snd_latch;
logic                          snd_stb, snd_rstn, main_flag;

int          mismatches = 0;
int          timeouts   = 0;
logic [31:0] lfsr       = 32'h2ce94bd6;

bubl_main_bus u_dut (.*);

initial begin
    clk24 = 1'b0;
    forever #20 clk24 = ~clk24;   // 25 MHz stand-in for the 24 MHz board clock
end

////////////////////
// Stimulus helpers

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
endfunction

// One LFSR step per bit with the newest bit in bit 0
task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    repeat (count) begin
        lfsr  = lfsr_next(lfsr);
        value = {value[30:0], lfsr[0]};
    end
endtask

task automatic bus_idle();
    bus.mreq_n = 1'b1;
    bus.iorq_n = 1'b1;
    bus.rd_n   = 1'b1;
    bus.wr_n   = 1'b1;
endtask

// Write held for exactly one clock and released on the next falling edge
task automatic mem_write(input logic [`BUBL_ADDR_W-1:0] addr,
                         input logic [`BUBL_DATA_W-1:0] data);
    @(negedge clk24);
    bus.addr   = addr;
    bus.wdata  = data;
    bus.mreq_n = 1'b0;
    bus.wr_n   = 1'b0;
    @(negedge clk24);
    bus_idle();
endtask

task automatic mem_read(input logic [`BUBL_ADDR_W-1:0] addr, input int latency,
                        output logic [`BUBL_DATA_W-1:0] data);
    @(negedge clk24);
    bus.addr   = addr;
    bus.mreq_n = 1'b0;
    bus.rd_n   = 1'b0;
    repeat (latency) @(negedge clk24);
    data = rd_data;
    bus_idle();
endtask

////////////////////
// Checks

task automatic check_byte(input string name, input logic [`BUBL_DATA_W-1:0] expected,
                          input logic [`BUBL_DATA_W-1:0] actual);
    if (actual !== expected) begin
        $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        mismatches++;
    end
endtask

task automatic check_rom_addr(input string name,
                              input logic [`BUBL_ROM_ADDR_W-1:0] expected,
                              input logic [`BUBL_ROM_ADDR_W-1:0] actual);
    if (actual !== expected) begin
        $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        mismatches++;
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("mismatch %s: expected %b, actual %b", name, expected, actual);
        mismatches++;
    end
endtask

`include "bubl_tests.svh"

initial begin
    rst        = 1'b1;
    game       = bubl_pkg::GAME_TOKIO;
    bus        = '0;
    bus_idle();
    cab        = '0;
    rom_data   = '0;
    vram_dout  = '0;
    pal_dout   = '0;
    work_dout  = '0;
    comm_dout  = '0;
    main_latch = '0;
    snd_flag   = 1'b0;
    main_stb   = 1'b0;
    repeat (9) @(posedge clk24);
    test_reset_values();   // Spans the last reset cycle
    rst = 1'b0;

    test_rom_banking();
    test_read_mux();
    test_chip_selects();
    test_ctrl_regs();
    test_sound_link();
    test_handshake();
    test_cabinet();

    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
        $display("PASS: all tests");
    else
        $display("FAIL: see errors above");
    $finish;
end

endmodule

// File: src/bubl_addr_decode.sv
`timescale 1ns/1ns
`include "bubl_defines.svh"

module bubl_addr_decode (
    input  bubl_pkg::cpu_bus_t bus,
    input  bubl_pkg::game_t    game,
    output bubl_pkg::sel_t     sel
);

logic [`BUBL_ADDR_W-1:0] a;
logic                    mem;
logic                    mem_wr;
logic                    mem_rd;

assign a      = bus.addr;
assign mem    = !bus.mreq_n;
assign mem_wr = mem && !bus.wr_n;
assign mem_rd = mem && bus.wr_n;   // Anything that is not a write

////////////////////
// Common windows

always_comb begin
    sel = '0;

    sel.rom  = mem && (!a[15] || a[15:14] == 2'b10);      // 0000-BFFF
    sel.vram = mem && a[15:13] == 3'b110;                 // C000-DFFF
    sel.work = mem && a[15:13] == 3'b111 && a[12:11] != 2'b11;
    sel.pal  = mem && a[15:9] == 7'b1111_100;             // F800-F9FF

    ////////////////////
    // Game dependent windows

    if (game == bubl_pkg::GAME_TOKIO) begin
        sel.sound   = mem    && a[15:7] == 9'b1111_1100_0;  // FC00-FC7F
        sel.misc    = mem_wr && a[15:7] == 9'b1111_1010_1;  // FA80-FAFF
        sel.flip    = mem_wr && a[15:7] == 9'b1111_1011_0;  // FB00-FB7F
        sel.sub_nmi = mem_wr && a[15:7] == 9'b1111_1011_1;  // FB80-FBFF
        sel.comm    = mem    && a[15:9] == 7'b1111_111;     // FE00-FFFF
        // Shares FA00 with the watchdog, which is gone
        sel.cabinet = mem_rd && a[15:7] == 9'b1111_1010_0;
    end else begin
        sel.sound   = mem    && a[15:7] == 9'b1111_1010_0;   // FA00-FA7F
        sel.misc    = mem_wr && a[15:6] == 10'b1111_1011_01; // FB40-FB7F
        sel.sub_nmi = mem_wr && a[15:6] == 10'b1111_1011_00; // FB00-FB3F
        sel.comm    = mem    && a[15:10] == 6'b1111_11;      // FC00-FFFF
        // Flip lives in the misc register, cabinet goes through the MCU
    end
end

endmodule

// File: src/bubl_cab_inputs.sv
`timescale 1ns/1ns
`include "bubl_defines.svh"

module bubl_cab_inputs (
    input                             clk24,
    input  bubl_pkg::cab_in_t         cab,
    input  [2:0]                      addr_low,
    output logic [`BUBL_DATA_W-1:0]   cab_byte
);

// Player byte as the board wires it, inputs are active low upstream
function automatic logic [7:0] player_byte(
    input logic       start,
    input logic [5:0] joy
);
    player_byte = {1'b1, start, joy[4], joy[5], joy[3:2], joy[0], joy[1]};
endfunction

////////////////////
// Port latch

// Registered here, the read mux adds one more stage on top
always_ff @(posedge clk24) begin
    case (addr_low)
        3'd3: cab_byte <= cab.dipsw_a;
        3'd4: cab_byte <= cab.dipsw_b;
        3'd5: cab_byte <= {4'hF, ~cab.coin, 2'b11};  // Upper nibble unused
        3'd6: cab_byte <= player_byte(cab.start_button[0], cab.joy1);
        3'd7: cab_byte <= player_byte(cab.start_button[1], cab.joy2);
        default: cab_byte <= `BUBL_FILL;
    endcase
end

endmodule

// File: src/bubl_ctrl_regs.sv
`timescale 1ns/1ns
`include "bubl_defines.svh"

module bubl_ctrl_regs (
    input                                 clk24,
    input                                 rst,
    input  bubl_pkg::game_t               game,
    input  bubl_pkg::cpu_bus_t            bus,
    input  bubl_pkg::sel_t                sel,
    output logic [`BUBL_ROM_ADDR_W-1:0]   rom_addr,
    output logic                          black_n,
    output logic                          flip,
    output logic                          sub_rst_n,
    output logic                          mcu_rst
);

localparam logic [`BUBL_BANK_W-1:0] BANK_XOR  = `BUBL_BUBL_BANK_XOR;
localparam logic [`BUBL_BANK_W:0]   BANK_BASE = `BUBL_BANK_BASE;

logic [`BUBL_BANK_W-1:0] bank;
logic [`BUBL_BANK_W:0]   bank_page;
logic                    tokio;
logic                    flip_we;

assign tokio   = game == bubl_pkg::GAME_TOKIO;
assign flip_we = tokio ? sel.flip : sel.misc;  // BB keeps flip in misc

////////////////////
// Misc register

always_ff @(posedge clk24, posedge rst) begin
    if (rst) begin
        bank      <= '0;
        black_n   <= 1'b0;
        sub_rst_n <= 1'b0;   // Sub CPU held until the game releases it
        mcu_rst   <= 1'b1;
        flip      <= 1'b0;
    end else begin
        if (sel.misc) begin
            black_n <= bus.wdata[6];
            if (tokio) begin
                bank      <= bus.wdata[2:0];
                sub_rst_n <= 1'b1;
                mcu_rst   <= 1'b1;
            end else begin
                bank      <= bus.wdata[2:0] ^ BANK_XOR;
                sub_rst_n <= bus.wdata[4];
                mcu_rst   <= ~bus.wdata[5];
            end
        end
        if (flip_we)
            flip <= bus.wdata[7];
    end
end

////////////////////
// ROM address

assign bank_page = {1'b0, bank} + BANK_BASE;  // Skip the two fixed pages

assign rom_addr = bus.addr[15] ?
    {bank_page, bus.addr[13:0]} :                            // 8000-BFFF banked
    {{(`BUBL_ROM_ADDR_W-15){1'b0}}, bus.addr[14:0]};         // Fixed 32kB

endmodule

// File: src/bubl_main_bus.sv
`timescale 1ns/1ns
`include "bubl_defines.svh"

module bubl_main_bus (
    input                                 clk24,
    input                                 rst,
    input  bubl_pkg::game_t               game,
    input  bubl_pkg::cpu_bus_t            bus,
    input  bubl_pkg::cab_in_t             cab,
    // External memories
    input        [`BUBL_DATA_W-1:0]       rom_data,
    input        [`BUBL_DATA_W-1:0]       vram_dout,
    input        [`BUBL_DATA_W-1:0]       pal_dout,
    input        [`BUBL_DATA_W-1:0]       work_dout,
    input        [`BUBL_DATA_W-1:0]       comm_dout,
    // Sound CPU side
    input        [`BUBL_DATA_W-1:0]       main_latch,
    input                                 snd_flag,
    input                                 main_stb,
    output       [`BUBL_DATA_W-1:0]       rd_data,
    output       [`BUBL_ROM_ADDR_W-1:0]   rom_addr,
    output                                rom_cs,
    output                                vram_cs,
    output                                pal_cs,
    output                                work_cs,
    output                                sub_nmi,
    output                                black_n,
    output                                flip,
    output                                sub_rst_n,
    output                                mcu_rst,
    output       [`BUBL_DATA_W-1:0]       snd_latch,
    output                                snd_stb,
    output                                snd_rstn,
    output                                main_flag
);

bubl_pkg::sel_t          sel;
logic [`BUBL_DATA_W-1:0] cab_byte;

assign rom_cs  = sel.rom;
assign vram_cs = sel.vram;
assign pal_cs  = sel.pal;
assign work_cs = sel.work;
assign sub_nmi = sel.sub_nmi;   // Level while the write lasts

////////////////////
// Input side

bubl_cab_inputs u_cab (
    .clk24      ( clk24         ),
    .cab        ( cab           ),
    .addr_low   ( bus.addr[2:0] ),
    .cab_byte   ( cab_byte      )
);

////////////////////
// Decode and control

bubl_addr_decode u_decode (
    .bus        ( bus           ),
    .game       ( game          ),
    .sel        ( sel           )
);

bubl_ctrl_regs u_ctrl (
    .clk24      ( clk24         ),
    .rst        ( rst           ),
    .game       ( game          ),
    .bus        ( bus           ),
    .sel        ( sel           ),
    .rom_addr   ( rom_addr      ),
    .black_n    ( black_n       ),
    .flip       ( flip          ),
    .sub_rst_n  ( sub_rst_n     ),
    .mcu_rst    ( mcu_rst       )
);

////////////////////
// Output side

bubl_read_mux u_rdmux (
    .clk24      ( clk24         ),
    .rst        ( rst           ),
    .bus        ( bus           ),
    .sel        ( sel           ),
    .game       ( game          ),
    .rom_data   ( rom_data      ),
    .vram_dout  ( vram_dout     ),
    .pal_dout   ( pal_dout      ),
    .work_dout  ( work_dout     ),
    .comm_dout  ( comm_dout     ),
    .main_latch ( main_latch    ),
    .snd_flag   ( snd_flag      ),
    .main_flag  ( main_flag     ),
    .cab_byte   ( cab_byte      ),
    .rd_data    ( rd_data       )
);

bubl_sound_link u_sound (
    .clk24      ( clk24         ),
    .rst        ( rst           ),
    .bus        ( bus           ),
    .sel        ( sel           ),
    .main_stb   ( main_stb      ),
    .snd_latch  ( snd_latch     ),
    .snd_stb    ( snd_stb       ),
    .snd_rstn   ( snd_rstn      ),
    .main_flag  ( main_flag     )
);

endmodule

// File: src/bubl_pkg.sv
`include "bubl_defines.svh"

package bubl_pkg;

////////////////////
// Game selection

// Picks the memory map of the board
typedef enum logic {
    GAME_BUBL  = 1'b0,
    GAME_TOKIO = 1'b1
} game_t;

////////////////////
// Main CPU bus

typedef struct packed {
    logic [`BUBL_ADDR_W-1:0] addr;
    logic [`BUBL_DATA_W-1:0] wdata;
    logic                    mreq_n;
    logic                    iorq_n;
    logic                    rd_n;
    logic                    wr_n;
} cpu_bus_t;

// One bit per decoded window
typedef struct packed {
    logic rom;
    logic vram;
    logic work;
    logic pal;
    logic comm;     // Shared RAM with the MCU
    logic sound;
    logic misc;     // Write only
    logic flip;     // Write only, Tokio
    logic sub_nmi;  // Write only
    logic cabinet;  // Read only, Tokio
} sel_t;

////////////////////
// Cabinet

typedef struct packed {
    logic [1:0] start_button;
    logic [1:0] coin;
    logic [5:0] joy1;
    logic [5:0] joy2;
    logic [7:0] dipsw_a;
    logic [7:0] dipsw_b;
} cab_in_t;

// Read data sources, listed in priority order
typedef enum logic [3:0] {
    RD_ROM, RD_VRAM, RD_PAL, RD_WORK, RD_COMM,
    RD_VECTOR, RD_SOUND, RD_CAB, RD_FILL
} rd_src_t;

endpackage

// File: src/bubl_read_mux.sv
`timescale 1ns/1ns
`include "bubl_defines.svh"

module bubl_read_mux (
    input                               clk24,
    input                               rst,
    input  bubl_pkg::cpu_bus_t          bus,
    input  bubl_pkg::sel_t              sel,
    input  bubl_pkg::game_t             game,
    input        [`BUBL_DATA_W-1:0]     rom_data,
    input        [`BUBL_DATA_W-1:0]     vram_dout,
    input        [`BUBL_DATA_W-1:0]     pal_dout,
    input        [`BUBL_DATA_W-1:0]     work_dout,
    input        [`BUBL_DATA_W-1:0]     comm_dout,
    input        [`BUBL_DATA_W-1:0]     main_latch,
    input                               snd_flag,
    input                               main_flag,
    input        [`BUBL_DATA_W-1:0]     cab_byte,
    output logic [`BUBL_DATA_W-1:0]     rd_data
);

bubl_pkg::rd_src_t       src;
logic [`BUBL_DATA_W-1:0] next_data;

////////////////////
// Source priority

always_comb begin
    if (sel.rom)             src = bubl_pkg::RD_ROM;
    else if (sel.vram)       src = bubl_pkg::RD_VRAM;
    else if (sel.pal)        src = bubl_pkg::RD_PAL;
    else if (sel.work)       src = bubl_pkg::RD_WORK;
    else if (sel.comm)       src = bubl_pkg::RD_COMM;
    else if (!bus.iorq_n)    src = bubl_pkg::RD_VECTOR;  // Interrupt acknowledge
    else if (sel.sound)      src = bubl_pkg::RD_SOUND;
    else if (sel.cabinet)    src = bubl_pkg::RD_CAB;
    else                     src = bubl_pkg::RD_FILL;
end

always_comb begin
    case (src)
        bubl_pkg::RD_ROM:    next_data = rom_data;
        bubl_pkg::RD_VRAM:   next_data = vram_dout;
        bubl_pkg::RD_PAL:    next_data = pal_dout;
        bubl_pkg::RD_WORK:   next_data = work_dout;
        bubl_pkg::RD_COMM:   next_data = game == bubl_pkg::GAME_TOKIO ?
                                         `BUBL_TOKIO_COMM : comm_dout;
        bubl_pkg::RD_VECTOR: next_data = `BUBL_INT_VECTOR;
        // Odd offsets give the status byte, even ones the reply latch
        bubl_pkg::RD_SOUND:  next_data = bus.addr[0] ?
                                         {6'h3F, main_flag, snd_flag} : main_latch;
        bubl_pkg::RD_CAB:    next_data = cab_byte;
        default:             next_data = `BUBL_FILL;
    endcase
end

always_ff @(posedge clk24, posedge rst) begin
    if (rst)
        rd_data <= `BUBL_FILL;
    else
        rd_data <= next_data;
end

endmodule

// File: src/bubl_sound_link.sv
`timescale 1ns/1ns
`include "bubl_defines.svh"

module bubl_sound_link (
    input                               clk24,
    input                               rst,
    input  bubl_pkg::cpu_bus_t          bus,
    input  bubl_pkg::sel_t              sel,
    input                               main_stb,
    output logic [`BUBL_DATA_W-1:0]     snd_latch,
    output logic                        snd_stb,
    output logic                        snd_rstn,
    output logic                        main_flag
);

logic snd_wr;
logic snd_rd;
logic latch_wr;
logic last_stb;
logic stb_rise;

assign snd_wr   = sel.sound && !bus.wr_n;
assign snd_rd   = sel.sound && !bus.rd_n;
assign latch_wr = snd_wr && bus.addr[1:0] == 2'd0;
assign stb_rise = main_stb && !last_stb;

////////////////////
// Main to sound

always_ff @(posedge clk24) begin
    if (latch_wr)
        snd_latch <= bus.wdata;
end

always_ff @(posedge clk24, posedge rst) begin
    if (rst) begin
        snd_stb  <= 1'b0;
        snd_rstn <= 1'b1;    // Sound CPU runs from power up
    end else begin
        snd_stb <= latch_wr;  // High for every written cycle
        if (snd_wr && bus.addr[1:0] == 2'd3)
            snd_rstn <= ~bus.wdata[0];
    end
end

////////////////////
// Sound to main flag

// Set by the sound side strobe, cleared when the main CPU reads the window.
// A new strobe wins over a read in the same cycle so no message is lost.
always_ff @(posedge clk24, posedge rst) begin
    if (rst) begin
        last_stb  <= 1'b0;
        main_flag <= 1'b0;
    end else begin
        last_stb <= main_stb;
        if (stb_rise)
            main_flag <= 1'b1;
        else if (snd_rd)
            main_flag <= 1'b0;
    end
end

endmodule
